// File: source/cart_pkg.sv
package cart_pkg;

  //////////////////////////////////////////////////
  // Bus and memory widths
  //////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;  // Console address
  typedef logic [22:0] rom_addr_t;   // ROM word address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;

  typedef logic [3:0]  dly_cnt_t;    // MCU access wait counter
  typedef logic [17:0] dead_cnt_t;   // Console liveness counter

  //////////////////////////////////////////////////
  // Timing
  //////////////////////////////////////////////////

  // Control line history length
  localparam int SYNC_DEPTH = 8;

  // Address and data sample stages
  localparam int ADDR_PIPE = 7;

  // Wait count of one MCU ROM access
  localparam dly_cnt_t ROM_CYCLE_LEN = dly_cnt_t'(7);

  // CPU clock low for 1 ms at CLK2
  localparam dead_cnt_t SNES_DEAD_TIMEOUT = dead_cnt_t'(96000);

  //////////////////////////////////////////////////
  // MCU access FSM
  //////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ACC_IDLE    = 5'b00001,
    ACC_RD_ADDR = 5'b00010,
    ACC_RD_END  = 5'b00100,
    ACC_WR_ADDR = 5'b01000,
    ACC_WR_END  = 5'b10000
  } acc_state_t;

endpackage

// File: source/snes_bus_if.sv
`timescale 1ns/1ps

// Conditioned console bus, one driver and several listeners
interface snes_bus_if;

  cart_pkg::snes_addr_t addr;     // Filtered address
  cart_pkg::byte_t      data_in;  // Filtered data
  logic                 rd;       // Low active
  logic                 wr;       // Low active
  logic                 cpu_clk;
  logic                 cpu_clk_raw;  // Single sample, unfiltered
  logic                 rom_hit;

  // One cycle strobes
  logic                 rd_start;
  logic                 wr_end;
  logic                 cycle_start;
  logic                 cycle_end;

  modport src (output addr, data_in, rd, wr, cpu_clk, cpu_clk_raw, rom_hit,
               rd_start, wr_end, cycle_start, cycle_end);

  modport dst (input addr, data_in, rd, wr, cpu_clk, cpu_clk_raw, rom_hit,
               rd_start, wr_end, cycle_start, cycle_end);

endinterface

// File: source/rom_req_if.sv
`timescale 1ns/1ps

// MCU access path between the FSM and the ROM port
interface rom_req_if;

  logic                 rd_hit;  // FSM in read address phase
  logic                 wr_hit;  // FSM in write address phase
  cart_pkg::snes_addr_t addr;    // Latched MCU address
  cart_pkg::byte_t      wdata;   // Latched MCU write byte
  cart_pkg::byte_t      rdata;   // Lane byte from the ROM

  modport ctrl (
    output rd_hit, wr_hit, addr, wdata,
    input  rdata
  );

  modport port (
    input  rd_hit, wr_hit, addr, wdata,
    output rdata
  );

endinterface

// File: source/snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync (
  input  logic                 CLK2,
  input  logic                 rst_n,
  input  cart_pkg::snes_addr_t snes_addr,
  input  cart_pkg::byte_t      snes_data_in,
  input  logic                 snes_rd,
  input  logic                 snes_wr,
  input  logic                 snes_romsel,
  input  logic                 snes_cpu_clk,
  snes_bus_if.src              bus
);

  localparam int D = cart_pkg::SYNC_DEPTH;
  localparam int P = cart_pkg::ADDR_PIPE;

  logic [D-1:0] rd_q;
  logic [D-1:0] wr_q;
  logic [D-1:0] clk_q;
  logic [D-1:0] romsel_q;

  cart_pkg::snes_addr_t addr_pipe [P];
  cart_pkg::byte_t      data_pipe [P];

  //////////////////////////////////////////////////
  // Control sample history
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_q     <= '1;  // Bus idle
      wr_q     <= '1;
      clk_q    <= '0;
      romsel_q <= '1;
    end else begin
      rd_q     <= {rd_q[D-2:0], snes_rd};
      wr_q     <= {wr_q[D-2:0], snes_wr};
      clk_q    <= {clk_q[D-2:0], snes_cpu_clk};
      romsel_q <= {romsel_q[D-2:0], snes_romsel};
    end
  end

  // Two adjacent samples must agree on high, so a one-cycle glitch is dropped
  assign bus.rd          = rd_q[2] & rd_q[1];
  assign bus.wr          = wr_q[2] & wr_q[1];
  assign bus.cpu_clk     = clk_q[2] & clk_q[1];
  assign bus.cpu_clk_raw = clk_q[0];
  assign bus.rom_hit     = ~(romsel_q[2] & romsel_q[1]);

  //////////////////////////////////////////////////
  // Edge strobes from six-sample windows
  //////////////////////////////////////////////////

  // Read low for three samples after being high
  assign bus.rd_start    = ((rd_q[D-2:1] | rd_q[D-1:2]) == 6'b111100);
  // Write back high after a low stretch
  assign bus.wr_end      = ((wr_q[D-2:1] & wr_q[D-1:2]) == 6'b000001);
  assign bus.cycle_start = ((clk_q[D-1:2] & clk_q[D-2:1]) == 6'b000011);  // Rising
  assign bus.cycle_end   = ((clk_q[D-1:2] | clk_q[D-2:1]) == 6'b111000);  // Falling

  //////////////////////////////////////////////////
  // Address and data pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= snes_addr;
    data_pipe[0] <= snes_data_in;
    for (int i = 1; i < P; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // Last two stages agree
  assign bus.addr    = addr_pipe[P-1] & addr_pipe[P-2];
  assign bus.data_in = data_pipe[P-1] & data_pipe[P-2];

endmodule

// File: source/snes_liveness.sv
`timescale 1ns/1ps

module snes_liveness (
  input  logic    CLK2,
  input  logic    rst_n,
  snes_bus_if.dst bus,
  output logic    dead,
  output logic    snes_reset_strobe
);

  cart_pkg::dead_cnt_t dead_cnt;

  // Counts CPU clock low time, frozen once the console is declared dead
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (bus.cpu_clk_raw) begin
      dead_cnt <= '0;
    end else if (!dead) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead              <= 1'b1;  // Assume no console until a clock shows up
      snes_reset_strobe <= 1'b0;
    end else begin
      snes_reset_strobe <= 1'b0;
      if (bus.cpu_clk_raw) begin
        dead              <= 1'b0;
        snes_reset_strobe <= dead;  // Console just came back
      end else if (dead_cnt > cart_pkg::SNES_DEAD_TIMEOUT) begin
        dead <= 1'b1;
      end
    end
  end

  a_strobe_single : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    snes_reset_strobe |=> !snes_reset_strobe
  ) else $error("snes_reset_strobe held for two cycles");

endmodule

// File: source/rom_access_ctrl.sv
`timescale 1ns/1ps

module rom_access_ctrl (
  input  logic                 CLK2,
  input  logic                 rst_n,
  snes_bus_if.dst              bus,
  input  logic                 dead,
  input  cart_pkg::snes_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_wdata,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  output logic                 mcu_rdy,
  rom_req_if.ctrl              req
);

  cart_pkg::acc_state_t state;
  cart_pkg::dly_cnt_t   dly;
  cart_pkg::snes_addr_t addr_q;
  cart_pkg::byte_t      wdata_q;
  logic                 rd_pend;
  logic                 wr_pend;
  logic                 free_strobe;
  logic                 free_slot;
  logic                 revive;
  logic                 acc_last;

  //////////////////////////////////////////////////
  // Request latch
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if ((mcu_rrq || mcu_wrq) && mcu_rdy) begin
      addr_q  <= mcu_addr;
      wdata_q <= mcu_wdata;
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq && mcu_rdy) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq && mcu_rdy) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (acc_last) begin
      rd_pend <= 1'b0;  // Ready rises together with END
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Free bus slots
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~bus.rom_hit;  // Console cycle not aimed at ROM
    end
  end

  assign free_slot = bus.cycle_end | free_strobe;
  assign revive    = dead & bus.cpu_clk_raw;
  assign acc_last  = (state inside {cart_pkg::ACC_RD_ADDR, cart_pkg::ACC_WR_ADDR}) &&
                     (dly == '0) && !revive;

  //////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state <= cart_pkg::ACC_IDLE;
      dly   <= '0;
    end else if (revive) begin
      state <= cart_pkg::ACC_IDLE;  // Abort, request stays pending
    end else begin
      unique case (state)
        cart_pkg::ACC_IDLE: begin
          if (free_slot || dead) begin
            dly <= cart_pkg::ROM_CYCLE_LEN;
            if (rd_pend) state <= cart_pkg::ACC_RD_ADDR;
            else if (wr_pend) state <= cart_pkg::ACC_WR_ADDR;
          end
        end
        cart_pkg::ACC_RD_ADDR: begin
          dly <= dly - 1'b1;
          if (dly == '0) state <= cart_pkg::ACC_RD_END;
        end
        cart_pkg::ACC_WR_ADDR: begin
          dly <= dly - 1'b1;
          if (dly == '0) state <= cart_pkg::ACC_WR_END;
        end
        default: state <= cart_pkg::ACC_IDLE;  // Both END states
      endcase
    end
  end

  assign req.rd_hit = (state == cart_pkg::ACC_RD_ADDR);
  assign req.wr_hit = (state == cart_pkg::ACC_WR_ADDR);
  assign req.addr   = addr_q;
  assign req.wdata  = wdata_q;

  a_req_when_ready : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    (mcu_rrq || mcu_wrq) |-> mcu_rdy
  ) else $error("MCU request while mcu_rdy low");

  a_hit_exclusive : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    !(req.rd_hit && req.wr_hit)
  ) else $error("rd_hit and wr_hit both high");

endmodule

// File: source/rom_port_mux.sv
`timescale 1ns/1ps

module rom_port_mux (
  input  logic                  CLK2,
  input  logic                  rst_n,
  snes_bus_if.dst               bus,
  rom_req_if.port               req,
  output cart_pkg::rom_addr_t   rom_addr,
  input  cart_pkg::rom_word_t   rom_rdata,
  output cart_pkg::rom_word_t   rom_wdata,
  output logic                  rom_wdata_en,
  output logic                  rom_we,
  output logic                  rom_bhe,
  output logic                  rom_ble,
  output cart_pkg::byte_t       snes_data_out,
  output logic                  snes_data_drive,
  output cart_pkg::byte_t       mcu_rdata
);

  cart_pkg::snes_addr_t sel_addr;
  logic                 mcu_hit;
  logic                 lane;  // High selects the low byte

  //////////////////////////////////////////////////
  // Address steering
  //////////////////////////////////////////////////

  assign mcu_hit  = req.rd_hit | req.wr_hit;
  assign sel_addr = mcu_hit ? req.addr : bus.addr;
  assign rom_addr = sel_addr[23:1];
  assign lane     = sel_addr[0];

  assign rom_bhe  = lane;   // Low active so an odd address masks the high byte
  assign rom_ble  = ~lane;

  //////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////

  assign rom_we       = ~req.wr_hit;
  assign rom_wdata_en = req.wr_hit;
  assign rom_wdata    = lane ? {8'h00, req.wdata} : {req.wdata, 8'h00};

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  assign req.rdata = lane ? rom_rdata[7:0] : rom_rdata[15:8];

  assign snes_data_out   = req.rdata;
  assign snes_data_drive = ~bus.rd & bus.rom_hit;

  // Reloads on every address phase cycle so the last load wins
  always_ff @(posedge CLK2) begin
    if (req.rd_hit) begin
      mcu_rdata <= req.rdata;
    end
  end

endmodule

// File: source/cart_bus_top.sv
`timescale 1ns/1ps

module cart_bus_top (
  input  logic                 CLK2,
  input  logic                 rst_n,

  // Console bus
  input  cart_pkg::snes_addr_t snes_addr,
  input  cart_pkg::byte_t      snes_data_in,
  output cart_pkg::byte_t      snes_data_out,
  output logic                 snes_data_drive,
  input  logic                 snes_rd,
  input  logic                 snes_wr,
  input  logic                 snes_romsel,
  input  logic                 snes_cpu_clk,
  output logic                 snes_reset_strobe,

  // ROM
  output cart_pkg::rom_addr_t  rom_addr,
  input  cart_pkg::rom_word_t  rom_rdata,
  output cart_pkg::rom_word_t  rom_wdata,
  output logic                 rom_wdata_en,
  output logic                 rom_we,
  output logic                 rom_bhe,
  output logic                 rom_ble,

  // MCU requests
  input  cart_pkg::snes_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_wdata,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  output logic                 mcu_rdy,
  output cart_pkg::byte_t      mcu_rdata
);

  logic dead;

  snes_bus_if bus_if ();
  rom_req_if  req_if ();

  snes_bus_sync u_sync (
    .CLK2, .rst_n, .snes_addr, .snes_data_in, .snes_rd, .snes_wr,
    .snes_romsel, .snes_cpu_clk, .bus(bus_if.src)
  );

  snes_liveness u_live (
    .CLK2, .rst_n, .bus(bus_if.dst), .dead, .snes_reset_strobe
  );

  rom_access_ctrl u_ctrl (
    .CLK2, .rst_n, .bus(bus_if.dst), .dead, .mcu_addr, .mcu_wdata,
    .mcu_rrq, .mcu_wrq, .mcu_rdy, .req(req_if.ctrl)
  );

  rom_port_mux u_mux (
    .CLK2, .rst_n, .bus(bus_if.dst), .req(req_if.port), .rom_addr, .rom_rdata,
    .rom_wdata, .rom_wdata_en, .rom_we, .rom_bhe, .rom_ble,
    .snes_data_out, .snes_data_drive, .mcu_rdata
  );

endmodule

// File: verif/tb_cart_tasks.svh
//////////////////////////////////////////////////
// MCU handshake
//////////////////////////////////////////////////

// One cycle request pulse that ready drops on the next edge
task automatic issue_request(input logic is_wr, input cart_pkg::snes_addr_t a,
                             input cart_pkg::byte_t wdata);
  mcu_addr  = a;
  mcu_wdata = wdata;
  mcu_rrq   = ~is_wr;
  mcu_wrq   = is_wr;
  step_cycles(1);
  mcu_rrq   = 1'b0;
  mcu_wrq   = 1'b0;
  check_val("mcu_rdy", 32'(mcu_rdy), 32'h0);
endtask

task automatic wait_ready(input int limit, input string what);
  int waited;
  waited = 0;
  while (!mcu_rdy && waited < limit) begin
    step_cycles(1);
    waited++;
  end
  if (!mcu_rdy) begin
    err_cnt++;
    $display("%s: mcu_rdy still low %0d cycles after the request", what, limit);
  end
endtask

// Dead console access takes at most 12 cycles
task automatic mcu_access(input logic is_wr, input cart_pkg::snes_addr_t a,
                          input cart_pkg::byte_t wdata);
  issue_request(is_wr, a, wdata);
  wait_ready(11, is_wr ? "MCU write" : "MCU read");
endtask

task automatic end_test(input string name, input int errs_before);
  if (err_cnt == errs_before) $display("%s: ok", name);
  else $display("%s: %0d error(s)", name, err_cnt - errs_before);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic read_while_dead();
  int                   errs;
  cart_pkg::snes_addr_t a;
  errs = err_cnt;
  for (int k = 0; k < 2; k++) begin
    a = 24'h3a_1c08 + 24'(k * 3);  // Even address first then odd
    mcu_access(1'b0, a, 8'h00);
    check_val("mcu_rdata", 32'(mcu_rdata), 32'(orig_byte(a)));
  end
  end_test("read_while_dead", errs);
endtask

task automatic write_while_dead();
  int              errs;
  cart_pkg::byte_t wb_odd;
  cart_pkg::byte_t wb_even;
  errs    = err_cnt;
  wb_odd  = rand_byte();
  wb_even = rand_byte();
  check_val("rom_we", 32'(rom_we), 32'h1);  // Idle ROM port
  check_val("rom_wdata_en", 32'(rom_wdata_en), 32'h0);
  mcu_access(1'b1, 24'h01_0013, wb_odd);
  mcu_access(1'b1, 24'h01_0020, wb_even);
  mcu_access(1'b0, 24'h01_0013, 8'h00);
  check_val("mcu_rdata", 32'(mcu_rdata), 32'(wb_odd));
  mcu_access(1'b0, 24'h01_0012, 8'h00);  // High lane untouched
  check_val("mcu_rdata", 32'(mcu_rdata), 32'(orig_byte(24'h01_0012)));
  mcu_access(1'b0, 24'h01_0020, 8'h00);
  check_val("mcu_rdata", 32'(mcu_rdata), 32'(wb_even));
  mcu_access(1'b0, 24'h01_0021, 8'h00);
  check_val("mcu_rdata", 32'(mcu_rdata), 32'(orig_byte(24'h01_0021)));
  end_test("write_while_dead", errs);
endtask

task automatic console_rom_read();
  int                   errs;
  cart_pkg::snes_addr_t a;
  errs         = err_cnt;
  snes_cpu_clk = 1'b1;  // Console comes alive
  snes_romsel  = 1'b0;
  snes_rd      = 1'b0;
  for (int k = 0; k < 2; k++) begin
    a         = (k == 0) ? 24'h7f_80a6 : 24'h7f_80e1;
    snes_addr = a;
    step_cycles(12);
    check_val("snes_data_drive", 32'(snes_data_drive), 32'h1);
    check_val("rom_addr", 32'(rom_addr), 32'(a[23:1]));
    check_val("snes_data_out", 32'(snes_data_out), 32'(orig_byte(a)));
  end
  snes_romsel = 1'b1;  // Not a ROM cycle
  step_cycles(12);
  check_val("snes_data_drive", 32'(snes_data_drive), 32'h0);
  snes_rd = 1'b1;
  step_cycles(12);
  end_test("console_rom_read", errs);
endtask

task automatic wait_for_free_slot();
  int                   errs;
  logic                 early;
  cart_pkg::snes_addr_t a;
  errs  = err_cnt;
  early = 1'b0;
  a     = 24'h12_3457;
  snes_cpu_clk = 1'b1;
  step_cycles(12);
  issue_request(1'b0, a, 8'h00);
  repeat (30) begin
    step_cycles(1);
    if (mcu_rdy) early = 1'b1;
  end
  if (early) begin
    err_cnt++;
    $display("wait_for_free_slot: mcu_rdy rose with no free bus slot");
  end
  snes_cpu_clk = 1'b0;  // Console cycle ends
  wait_ready(30, "wait_for_free_slot");
  check_val("mcu_rdata", 32'(mcu_rdata), 32'(orig_byte(a)));
  end_test("wait_for_free_slot", errs);
endtask

task automatic console_dead_and_revive();
  int   errs;
  int   high_cnt;
  int   pulses;
  logic prev;
  errs     = err_cnt;
  high_cnt = 0;
  pulses   = 0;
  prev     = 1'b0;
  snes_cpu_clk = 1'b0;
  step_cycles(DEAD_WAIT);
  mcu_access(1'b0, 24'h00_0ffe, 8'h00);  // Dead mode again
  check_val("mcu_rdata", 32'(mcu_rdata), 32'(orig_byte(24'h00_0ffe)));
  snes_cpu_clk = 1'b1;
  repeat (20) begin
    step_cycles(1);
    if (snes_reset_strobe) begin
      high_cnt++;
      if (!prev) pulses++;
    end
    prev = snes_reset_strobe;
  end
  check_val("snes_reset_strobe pulses", pulses, 1);
  check_val("snes_reset_strobe high cycles", high_cnt, 1);
  end_test("console_dead_and_revive", errs);
endtask

// File: verif/tb_cart_bus.sv
`timescale 1ns/1ps

module tb_cart_bus;

  // Longest test holds the CPU clock low past the dead timeout
  localparam int DEAD_WAIT   = int'(cart_pkg::SNES_DEAD_TIMEOUT) + 256;
  localparam int CYCLE_LIMIT = (DEAD_WAIT + 500) * 5 / 4;  // Short tests plus 25% margin

  logic                 CLK2;
  logic                 rst_n;
  cart_pkg::snes_addr_t snes_addr;
  cart_pkg::byte_t      snes_data_in;
  cart_pkg::byte_t      snes_data_out;
  logic                 snes_data_drive;
  logic                 snes_rd;
  logic                 snes_wr;
  logic                 snes_romsel;
  logic                 snes_cpu_clk;
  logic                 snes_reset_strobe;
  cart_pkg::rom_addr_t  rom_addr;
  cart_pkg::rom_word_t  rom_rdata;
  cart_pkg::rom_word_t  rom_wdata;
  logic                 rom_wdata_en;
  logic                 rom_we;
  logic                 rom_bhe;
  logic                 rom_ble;
  cart_pkg::snes_addr_t mcu_addr;
  cart_pkg::byte_t      mcu_wdata;
  logic                 mcu_rrq;
  logic                 mcu_wrq;
  logic                 mcu_rdy;
  cart_pkg::byte_t      mcu_rdata;

  int          err_cnt   = 0;
  int          chk_cnt   = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr      = 32'hcaf9_5d70;

  cart_pkg::rom_word_t rom_mem [64];

  cart_bus_top dut0 (.*);

  initial begin
    CLK2 = 1'b0;
    forever #4 CLK2 = ~CLK2;
  end

  //////////////////////////////////////////////////
  // ROM model of 64 words with low active byte lanes
  //////////////////////////////////////////////////

  assign rom_rdata = rom_mem[rom_addr[5:0]];

  always @(posedge CLK2) begin
    if (!rom_we) begin
      check_val("rom_wdata_en", 32'(rom_wdata_en), 32'h1);  // Data bus driven on writes
      if (!rom_ble) rom_mem[rom_addr[5:0]][7:0]  <= rom_wdata[7:0];
      if (!rom_bhe) rom_mem[rom_addr[5:0]][15:8] <= rom_wdata[15:8];
    end
  end

  initial begin
    for (int i = 0; i < 64; i++) begin
      rom_mem[i] = fill_word(i);
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Both bytes depend on all six index bits
  function automatic cart_pkg::rom_word_t fill_word(input int i);
    return {8'(i) ^ 8'h5a, 8'(i * 13) ^ 8'hc1};
  endfunction

  // Initial content of the byte at a console address
  function automatic cart_pkg::byte_t orig_byte(input cart_pkg::snes_addr_t a);
    cart_pkg::rom_word_t w;
    w = fill_word(int'(a[6:1]));
    return a[0] ? w[7:0] : w[15:8];  // Odd address takes the low byte
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic cart_pkg::byte_t rand_byte();
    cart_pkg::byte_t b;
    b = '0;
    for (int k = 0; k < 8; k++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      b    = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic step_cycles(input int n);
    repeat (n) @(posedge CLK2);
    #1;  // Drive and sample just after the edge
  endtask

  `include "tb_cart_tasks.svh"

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  always @(posedge CLK2) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Done: errors found");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    snes_addr    = '0;
    snes_data_in = '0;
    snes_rd      = 1'b1;
    snes_wr      = 1'b1;
    snes_romsel  = 1'b1;
    snes_cpu_clk = 1'b0;  // No console yet
    mcu_addr     = '0;
    mcu_wdata    = '0;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    repeat (8) @(posedge CLK2);
    #1 rst_n = 1'b1;
    step_cycles(2);

    read_while_dead();
    write_while_dead();
    console_rom_read();
    wait_for_free_slot();
    console_dead_and_revive();

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: cart_bus_top.f
+incdir+verif
source/cart_pkg.sv
source/snes_bus_if.sv
source/rom_req_if.sv
source/snes_bus_sync.sv
source/snes_liveness.sv
source/rom_access_ctrl.sv
source/rom_port_mux.sv
source/cart_bus_top.sv
verif/tb_cart_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cart_bus_top.f --top-module tb_cart_bus -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_cart_bus)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
